// ==== src/gate_cfg_pkg.sv ====
/* Configuration constants for the SWD programming gate
   Timing defaults at a 12 MHz clock, key material and counter widths */
package gate_cfg_pkg;

    // ====================
    // Timing defaults
    // ====================

    // 115200 baud from 12 MHz
    localparam int DEF_BIT_CLKS         = 104;
    // Five and ten seconds
    localparam int DEF_RESPONSE_TIMEOUT = 60_000_000;
    localparam int DEF_BLINK_TIMEOUT    = 120_000_000;
    // Two second check window
    localparam int DEF_BLINK_WINDOW     = 24_000_000;
    // Accepted blink period, 300 ms to 500 ms
    localparam int DEF_BLINK_PERIOD_MIN = 3_600_000;
    localparam int DEF_BLINK_PERIOD_MAX = 6_000_000;
    localparam int MIN_BLINKS           = 4;

    // ====================
    // Authentication
    // ====================

    localparam logic [31:0] SECRET_KEY = 32'hDEAD_BEEF;
    localparam logic [31:0] LFSR_SEED  = 32'hACE1_BABE;
    // Feedback from bits 31, 21, 1 and 0
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    // Counter widths
    localparam int TIMER_W   = 27;
    localparam int PERIOD_W  = 23;
    localparam int BIT_CNT_W = 8;

endpackage

// ==== src/gate_proto_pkg.sv ====
/* Host protocol for the SWD programming gate
   Command byte codes and the controller state encoding */
package gate_proto_pkg;

    // ====================
    // Command bytes
    // ====================

    localparam logic [7:0] CMD_PROG_REQUEST = 8'h01;
    localparam logic [7:0] CMD_CHALLENGE    = 8'h02;
    localparam logic [7:0] CMD_RESPONSE     = 8'h03;
    localparam logic [7:0] CMD_AUTH_OK      = 8'h04;
    localparam logic [7:0] CMD_AUTH_FAIL    = 8'h05;

    // ====================
    // Controller states
    // ====================

    typedef enum logic [3:0] {
        IDLE,
        SEND_CHALLENGE,
        WAIT_RESPONSE,
        VERIFY,
        SEND_AUTH_OK,
        SEND_AUTH_FAIL,
        // Jam line low only while waiting for the blink pattern
        RELEASE_JAM,
        WAIT_BLINK,
        RESTORE_JAM
    } auth_state_t;

endpackage

// ==== src/uart_rx.sv ====
/* UART receiver, 8N1
   Synchronises the line, finds the start bit and shifts in the data LSB first */
`timescale 1ns/1ps

module uart_rx import gate_cfg_pkg::*; #(
    parameter int BIT_CLKS = DEF_BIT_CLKS
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       rx_line,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam logic [BIT_CNT_W-1:0] FULL_BIT = BIT_CNT_W'(BIT_CLKS - 1);
    localparam logic [BIT_CNT_W-1:0] HALF_BIT = BIT_CNT_W'(BIT_CLKS / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t            state;
    logic                 rx_s1;
    logic                 rx_s2;
    logic [BIT_CNT_W-1:0] cnt;
    logic [2:0]           bit_idx;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_s1    <= rx_line;
            rx_s2    <= rx_s1;
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s2) state <= RX_START;
                end
                // Recheck at mid start bit, so glitches are dropped
                RX_START: if (cnt == HALF_BIT) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_s2 ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (cnt == FULL_BIT) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                default: if (cnt == FULL_BIT) begin
                    rx_valid <= 1'b1;
                    state    <= RX_IDLE;
                end
            endcase
        end
    end

    // Data shift, sampled near bit centre
    always_ff @(posedge CLK) begin
        if (state == RX_DATA && cnt == FULL_BIT) rx_data <= {rx_s2, rx_data[7:1]};
    end

    a_valid_single: assert property (@(posedge CLK) disable iff (!arst_n)
        rx_valid |=> !rx_valid);

endmodule

// ==== src/uart_tx.sv ====
/* UART transmitter, 8N1
   Sends one byte per start pulse and flags busy until the stop bit ends */
`timescale 1ns/1ps

module uart_tx import gate_cfg_pkg::*; #(
    parameter int BIT_CLKS = DEF_BIT_CLKS
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       tx_line
);

    localparam logic [BIT_CNT_W-1:0] FULL_BIT = BIT_CNT_W'(BIT_CLKS - 1);

    // Data bits then stop bit, shifted out from bit 0
    logic [8:0]           frame;
    logic [BIT_CNT_W-1:0] cnt;
    logic [3:0]           bit_idx;
    logic                 bit_end;

    assign bit_end = tx_busy && (cnt == FULL_BIT);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy <= 1'b0;
            tx_line <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                tx_busy <= 1'b1;
                tx_line <= 1'b0;
            end
        end else if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_line <= frame[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (tx_start && !tx_busy) frame <= {1'b1, tx_data};
        else if (bit_end)         frame <= {1'b1, frame[8:1]};
    end

    a_no_start_busy: assert property (@(posedge CLK) disable iff (!arst_n)
        tx_start |-> !tx_busy);

endmodule

// ==== src/phase_timer.sv ====
/* Phase timeout counter, response or blink limit selected by timer_long */
`timescale 1ns/1ps

module phase_timer import gate_cfg_pkg::*; #(
    parameter int RESPONSE_TIMEOUT = DEF_RESPONSE_TIMEOUT,
    parameter int BLINK_TIMEOUT    = DEF_BLINK_TIMEOUT
) (
    input  logic CLK,
    input  logic arst_n,
    input  logic timer_clear,
    input  logic timer_long,
    output logic expired
);

    localparam logic [TIMER_W-1:0] SHORT_LIMIT = TIMER_W'(RESPONSE_TIMEOUT);
    localparam logic [TIMER_W-1:0] LONG_LIMIT  = TIMER_W'(BLINK_TIMEOUT);

    logic [TIMER_W-1:0] count;
    logic [TIMER_W-1:0] limit;

    assign limit   = timer_long ? LONG_LIMIT : SHORT_LIMIT;
    // Stale count is hidden during the clear cycle
    assign expired = !timer_clear && (count >= limit);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)            count <= '0;
        else if (timer_clear)   count <= TIMER_W'(1);
        else if (count < limit) count <= count + 1'b1;
    end

endmodule

// ==== src/blink_detector.sv ====
/* Blink pattern detector
   Counts in-range periods of the target LED over one window while enabled */
`timescale 1ns/1ps

module blink_detector import gate_cfg_pkg::*; #(
    parameter int BLINK_WINDOW     = DEF_BLINK_WINDOW,
    parameter int BLINK_PERIOD_MIN = DEF_BLINK_PERIOD_MIN,
    parameter int BLINK_PERIOD_MAX = DEF_BLINK_PERIOD_MAX
) (
    input  logic CLK,
    input  logic arst_n,
    input  logic blink_in,
    input  logic blink_enable,
    output logic blink_ok
);

    localparam logic [TIMER_W-1:0]  WIN_END = TIMER_W'(BLINK_WINDOW);
    localparam logic [PERIOD_W-1:0] P_MIN   = PERIOD_W'(BLINK_PERIOD_MIN);
    localparam logic [PERIOD_W-1:0] P_MAX   = PERIOD_W'(BLINK_PERIOD_MAX);

    logic                blink_s1;
    logic                blink_s2;
    logic                blink_prev;
    logic                rise;
    logic                seen_edge;
    logic [PERIOD_W-1:0] period;
    logic [TIMER_W-1:0]  win_cnt;
    logic [3:0]          valid_cnt;
    logic                ok_q;

    assign rise     = blink_s2 && !blink_prev;
    assign blink_ok = blink_enable && ok_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            blink_s1   <= 1'b0;
            blink_s2   <= 1'b0;
            blink_prev <= 1'b0;
        end else begin
            blink_s1   <= blink_in;
            blink_s2   <= blink_s1;
            blink_prev <= blink_s2;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            seen_edge <= 1'b0;
            period    <= '0;
            win_cnt   <= '0;
            valid_cnt <= '0;
            ok_q      <= 1'b0;
        end else if (!blink_enable) begin
            seen_edge <= 1'b0;
            period    <= '0;
            win_cnt   <= '0;
            valid_cnt <= '0;
            ok_q      <= 1'b0;
        end else begin
            if (win_cnt != WIN_END) win_cnt <= win_cnt + 1'b1;
            // Decision lands exactly one window after enable
            if (win_cnt == WIN_END - 1'b1) ok_q <= (valid_cnt >= 4'(MIN_BLINKS));
            if (rise) begin
                // First edge only opens the first period
                seen_edge <= 1'b1;
                period    <= PERIOD_W'(1);
                if (seen_edge && period >= P_MIN && period <= P_MAX && valid_cnt != '1)
                    valid_cnt <= valid_cnt + 1'b1;
            end else if (period != '1) begin
                period <= period + 1'b1;
            end
        end
    end

    a_ok_after_window: assert property (@(posedge CLK) disable iff (!arst_n)
        blink_ok |-> blink_enable && (win_cnt == WIN_END));

endmodule

// ==== src/auth_controller.sv ====
/* Authentication controller
   Challenge LFSR, packet framing, response check and SWD jam line control */
`timescale 1ns/1ps

module auth_controller import gate_cfg_pkg::*, gate_proto_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic [7:0] tx_data,
    output logic       tx_start,
    input  logic       tx_busy,
    output logic       timer_clear,
    output logic       timer_long,
    input  logic       expired,
    output logic       blink_enable,
    input  logic       blink_ok,
    output logic       jam_ctrl
);

    auth_state_t state;
    logic [31:0] lfsr;
    logic [31:0] challenge;
    logic [31:0] response;
    logic [31:0] expected;
    logic [2:0]  byte_idx;
    logic        cmd_ok;
    logic        blink_done;
    logic        tx_ready;

    assign expected     = challenge ^ SECRET_KEY;
    assign tx_ready     = !tx_busy && !tx_start;
    assign timer_long   = (state == WAIT_BLINK);
    assign blink_enable = (state == WAIT_BLINK);

    // ====================
    // Challenge source
    // ====================

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) lfsr <= LFSR_SEED;
        else         lfsr <= {lfsr[30:0], ^(lfsr & LFSR_TAPS)};
    end

    // ====================
    // Main FSM
    // ====================

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            challenge   <= '0;
            response    <= '0;
            byte_idx    <= '0;
            cmd_ok      <= 1'b0;
            blink_done  <= 1'b0;
            tx_data     <= '0;
            tx_start    <= 1'b0;
            timer_clear <= 1'b0;
            jam_ctrl    <= 1'b1;
        end else begin
            tx_start    <= 1'b0;
            timer_clear <= 1'b0;
            blink_done  <= blink_enable && (blink_ok || expired);
            case (state)
                IDLE: begin
                    byte_idx <= '0;
                    if (rx_valid && rx_data == CMD_PROG_REQUEST) begin
                        challenge <= lfsr;
                        state     <= SEND_CHALLENGE;
                    end
                end
                // Command byte, then challenge MSB first
                SEND_CHALLENGE: if (tx_ready) begin
                    tx_start <= 1'b1;
                    byte_idx <= byte_idx + 1'b1;
                    case (byte_idx)
                        3'd0: tx_data <= CMD_CHALLENGE;
                        3'd1: tx_data <= challenge[31:24];
                        3'd2: tx_data <= challenge[23:16];
                        3'd3: tx_data <= challenge[15:8];
                        default: begin
                            tx_data     <= challenge[7:0];
                            byte_idx    <= '0;
                            timer_clear <= 1'b1;
                            state       <= WAIT_RESPONSE;
                        end
                    endcase
                end
                WAIT_RESPONSE: begin
                    if (expired) begin
                        state <= IDLE;
                    end else if (rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 3'd0) cmd_ok <= (rx_data == CMD_RESPONSE);
                        else                  response <= {response[23:0], rx_data};
                        if (byte_idx == 3'd4) begin
                            byte_idx <= '0;
                            state    <= cmd_ok ? VERIFY : SEND_AUTH_FAIL;
                        end
                    end
                end
                VERIFY: state <= (response == expected) ? SEND_AUTH_OK : SEND_AUTH_FAIL;
                // One status byte, then wait for its stop bit
                SEND_AUTH_OK, SEND_AUTH_FAIL: if (tx_ready) begin
                    if (byte_idx == 3'd0) begin
                        tx_data  <= (state == SEND_AUTH_OK) ? CMD_AUTH_OK : CMD_AUTH_FAIL;
                        tx_start <= 1'b1;
                        byte_idx <= 3'd1;
                    end else begin
                        byte_idx <= '0;
                        state    <= (state == SEND_AUTH_OK) ? RELEASE_JAM : IDLE;
                    end
                end
                RELEASE_JAM: begin
                    jam_ctrl    <= 1'b0;
                    timer_clear <= 1'b1;
                    state       <= WAIT_BLINK;
                end
                WAIT_BLINK: if (blink_done) begin
                    jam_ctrl <= 1'b1;
                    state    <= RESTORE_JAM;
                end
                // Detector and timer drop their phase here
                RESTORE_JAM: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    a_jam_only_in_blink: assert property (@(posedge CLK) disable iff (!arst_n)
        !jam_ctrl |-> state == WAIT_BLINK);

    // Response and challenge stay put from VERIFY until the release
    a_release_needs_match: assert property (@(posedge CLK) disable iff (!arst_n)
        state == RELEASE_JAM |-> cmd_ok && response == expected);

endmodule

// ==== src/swd_gate_top.sv ====
/* SWD programming gate, top level
   UART challenge-response authentication in front of the SWD jam line */
`timescale 1ns/1ps

module swd_gate_top import gate_cfg_pkg::*; #(
    parameter int BIT_CLKS         = DEF_BIT_CLKS,
    parameter int RESPONSE_TIMEOUT = DEF_RESPONSE_TIMEOUT,
    parameter int BLINK_TIMEOUT    = DEF_BLINK_TIMEOUT,
    parameter int BLINK_WINDOW     = DEF_BLINK_WINDOW,
    parameter int BLINK_PERIOD_MIN = DEF_BLINK_PERIOD_MIN,
    parameter int BLINK_PERIOD_MAX = DEF_BLINK_PERIOD_MAX
) (
    input  logic CLK,
    input  logic arst_n,
    input  logic uart_rx,
    output logic uart_tx,
    input  logic blink_in,
    // High jams the SWD clock
    output logic jam_ctrl
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       timer_clear;
    logic       timer_long;
    logic       expired;
    logic       blink_enable;
    logic       blink_ok;

    uart_rx #(.BIT_CLKS(BIT_CLKS)) u_rx (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .rx_line  (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx #(.BIT_CLKS(BIT_CLKS)) u_tx (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx_line  (uart_tx)
    );

    phase_timer #(
        .RESPONSE_TIMEOUT (RESPONSE_TIMEOUT),
        .BLINK_TIMEOUT    (BLINK_TIMEOUT)
    ) u_timer (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .timer_clear (timer_clear),
        .timer_long  (timer_long),
        .expired     (expired)
    );

    blink_detector #(
        .BLINK_WINDOW     (BLINK_WINDOW),
        .BLINK_PERIOD_MIN (BLINK_PERIOD_MIN),
        .BLINK_PERIOD_MAX (BLINK_PERIOD_MAX)
    ) u_blink (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .blink_in     (blink_in),
        .blink_enable (blink_enable),
        .blink_ok     (blink_ok)
    );

    auth_controller u_ctrl (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .tx_busy      (tx_busy),
        .timer_clear  (timer_clear),
        .timer_long   (timer_long),
        .expired      (expired),
        .blink_enable (blink_enable),
        .blink_ok     (blink_ok),
        .jam_ctrl     (jam_ctrl)
    );

endmodule

// ==== verification/swd_gate_tb.sv ====
/* SWD gate testbench
   UART host model, blink source and assertion checks on the authentication flow */
`timescale 1ns/1ps

module swd_gate_tb import gate_cfg_pkg::*, gate_proto_pkg::*;;

    // ====================
    // Scaled timing
    // ====================

    localparam int BIT_CLKS         = 8;
    localparam int RESPONSE_TIMEOUT = 2000;
    localparam int BLINK_TIMEOUT    = 1500;
    localparam int BLINK_WINDOW     = 600;
    localparam int PERIOD_MIN       = 40;
    localparam int PERIOD_MAX       = 80;
    localparam int RELEASE_MARGIN   = 100;
    // Whole sequence needs roughly 9300 cycles
    localparam int MAX_CYCLES       = 40_000;

    logic       CLK;
    logic       arst_n;
    logic       uart_rx_line;
    logic       uart_tx;
    logic       blink_in;
    logic       jam_ctrl;

    // Monitor and checker state
    logic [8:0] exp_q[$];
    logic [7:0] rx_q[$];
    logic       byte_seen;
    logic       byte_care;
    logic       byte_extra;
    logic       stop_seen;
    logic [7:0] seen_byte;
    logic [7:0] byte_exp;
    logic       jam_allowed;
    logic       line_quiet;
    logic [1:0] blink_mode;
    logic       jam_prev = 1'b1;
    logic       jam_rise;
    int         low_cnt = 0;
    int         mismatch_cnt = 0;
    int         fail_cnt = 0;
    int         seed;

    swd_gate_top #(
        .BIT_CLKS         (BIT_CLKS),
        .RESPONSE_TIMEOUT (RESPONSE_TIMEOUT),
        .BLINK_TIMEOUT    (BLINK_TIMEOUT),
        .BLINK_WINDOW     (BLINK_WINDOW),
        .BLINK_PERIOD_MIN (PERIOD_MIN),
        .BLINK_PERIOD_MAX (PERIOD_MAX)
    ) DUT (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .uart_rx  (uart_rx_line),
        .uart_tx  (uart_tx),
        .blink_in (blink_in),
        .jam_ctrl (jam_ctrl)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Length of the current jam release
    assign jam_rise = jam_ctrl && !jam_prev;

    always @(posedge CLK) begin
        jam_prev <= jam_ctrl;
        low_cnt  <= jam_ctrl ? 0 : low_cnt + 1;
    end

    // ====================
    // Blink source
    // ====================

    // Mode 1 gives a 60 cycle period, mode 2 a 20 cycle one
    initial begin : blink_source
        int half_cnt;
        half_cnt = 0;
        forever begin
            @(posedge CLK);
            half_cnt = half_cnt + 1;
            if (blink_mode == 2'd0) begin
                blink_in <= 1'b0;
                half_cnt = 0;
            end else if (half_cnt >= ((blink_mode == 2'd1) ? 30 : 10)) begin
                blink_in <= !blink_in;
                half_cnt = 0;
            end
        end
    end

    // ====================
    // UART TX monitor
    // ====================

    initial begin : uart_monitor
        logic [7:0] data;
        logic [8:0] entry;
        int         i;
        byte_seen  = 1'b0;
        byte_care  = 1'b0;
        byte_extra = 1'b0;
        stop_seen  = 1'b1;
        seen_byte  = '0;
        byte_exp   = '0;
        forever begin
            @(posedge CLK);
            if (arst_n && !uart_tx) begin
                // Centre of the start bit, then one sample per bit
                repeat (BIT_CLKS / 2) @(posedge CLK);
                for (i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(posedge CLK);
                    data[i] = uart_tx;
                end
                repeat (BIT_CLKS) @(posedge CLK);
                stop_seen  <= uart_tx;
                byte_extra <= (exp_q.size() == 0);
                entry = (exp_q.size() > 0) ? exp_q.pop_front() : 9'h000;
                byte_care  <= entry[8];
                byte_exp   <= entry[7:0];
                seen_byte  <= data;
                if (entry[8] && entry[7:0] == CMD_AUTH_OK && data == CMD_AUTH_OK)
                    jam_allowed <= 1'b1;
                rx_q.push_back(data);
                byte_seen <= 1'b1;
                @(posedge CLK);
                byte_seen <= 1'b0;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    a_byte_value: assert property (@(posedge CLK) disable iff (!arst_n)
        byte_seen && byte_care |-> seen_byte == byte_exp)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: UART byte %02h, expected %02h", $time, seen_byte,
                     byte_exp);
        end

    a_byte_expected: assert property (@(posedge CLK) disable iff (!arst_n)
        byte_seen |-> !byte_extra)
        else begin
            fail_cnt++;
            $display("Error at %0t: UART byte %02h sent when none was due", $time, seen_byte);
        end

    a_stop_bit: assert property (@(posedge CLK) disable iff (!arst_n)
        byte_seen |-> stop_seen)
        else begin
            fail_cnt++;
            $display("Error at %0t: UART byte %02h has no stop bit", $time, seen_byte);
        end

    a_line_idle: assert property (@(posedge CLK) disable iff (!arst_n)
        line_quiet |-> uart_tx)
        else begin
            fail_cnt++;
            $display("Error at %0t: UART TX line left idle while no reply was due", $time);
        end

    a_jam_gated: assert property (@(posedge CLK) disable iff (!arst_n)
        !jam_ctrl |-> jam_allowed)
        else begin
            fail_cnt++;
            $display("Error at %0t: jam line released without an AUTH_OK", $time);
        end

    a_good_blink_release: assert property (@(posedge CLK) disable iff (!arst_n)
        jam_rise && blink_mode == 2'd1 |->
            low_cnt >= BLINK_WINDOW && low_cnt < BLINK_TIMEOUT)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: jam line low for %0d cycles, expected window end",
                     $time, low_cnt);
        end

    a_bad_blink_release: assert property (@(posedge CLK) disable iff (!arst_n)
        jam_rise && blink_mode == 2'd2 |->
            low_cnt >= BLINK_TIMEOUT - RELEASE_MARGIN &&
            low_cnt <= BLINK_TIMEOUT + RELEASE_MARGIN)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: jam line low for %0d cycles, expected blink timeout",
                     $time, low_cnt);
        end

    // ====================
    // Host model
    // ====================

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge CLK);
            uart_rx_line <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge CLK);
        end
    endtask

    task automatic wait_bytes(input int count);
        int waited;
        waited = 0;
        while (rx_q.size() < count && waited < 2000) begin
            @(posedge CLK);
            waited++;
        end
        if (rx_q.size() < count) begin
            fail_cnt++;
            $display("Error at %0t: only %0d of %0d UART bytes arrived", $time, rx_q.size(),
                     count);
        end
    endtask

    task automatic wait_jam(input logic level, input int limit);
        int waited;
        waited = 0;
        while (jam_ctrl !== level && waited < limit) begin
            @(posedge CLK);
            waited++;
        end
        if (jam_ctrl !== level) begin
            fail_cnt++;
            $display("Error at %0t: jam line did not go to %0b within %0d cycles", $time,
                     level, limit);
        end
    endtask

    // Request byte, then the command byte and four challenge bytes of any value
    task automatic request_challenge(output logic [31:0] challenge);
        rx_q.delete();
        exp_q.push_back({1'b1, CMD_CHALLENGE});
        repeat (4) exp_q.push_back(9'h000);
        line_quiet <= 1'b0;
        send_byte(CMD_PROG_REQUEST);
        wait_bytes(5);
        if (rx_q.size() >= 5) challenge = {rx_q[1], rx_q[2], rx_q[3], rx_q[4]};
        else                  challenge = '0;
    endtask

    task automatic send_response(input logic [7:0] cmd, input logic [31:0] word);
        send_byte(cmd);
        send_byte(word[31:24]);
        send_byte(word[23:16]);
        send_byte(word[15:8]);
        send_byte(word[7:0]);
    endtask

    task automatic auth_and_blink(input logic [31:0] challenge, input logic [1:0] mode);
        blink_mode <= mode;
        exp_q.push_back({1'b1, CMD_AUTH_OK});
        send_response(CMD_RESPONSE, challenge ^ SECRET_KEY);
        wait_bytes(6);
        wait_jam(1'b0, 200);
        wait_jam(1'b1, BLINK_TIMEOUT + 200);
        jam_allowed <= 1'b0;
        blink_mode  <= 2'd0;
        repeat (20) @(posedge CLK);
    endtask

    task automatic auth_reject(input logic [7:0] cmd, input logic [31:0] word);
        logic [31:0] challenge;
        request_challenge(challenge);
        exp_q.push_back({1'b1, CMD_AUTH_FAIL});
        send_response(cmd, word ^ challenge);
        wait_bytes(6);
        line_quiet <= 1'b1;
        repeat (200) @(posedge CLK);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin : main_sequence
        logic [31:0] challenge;
        logic [31:0] flip;
        logic [7:0]  bad_cmd;
        arst_n       = 1'b0;
        uart_rx_line = 1'b1;
        blink_in     = 1'b0;
        blink_mode   = 2'd0;
        jam_allowed  = 1'b0;
        line_quiet   = 1'b1;
        seed         = 32'hba203c40;
        repeat (8) @(posedge CLK);
        arst_n <= 1'b1;

        // Quiet after reset
        repeat (200) @(posedge CLK);

        // Correct response with a good blink pattern
        request_challenge(challenge);
        auth_and_blink(challenge, 2'd1);

        // Wrong word, then wrong command byte
        flip = $random(seed);
        if (flip == 32'h0) flip = 32'h1;
        auth_reject(CMD_RESPONSE, SECRET_KEY ^ flip);
        bad_cmd = $random(seed);
        if (bad_cmd == CMD_RESPONSE) bad_cmd = 8'hA5;
        auth_reject(bad_cmd, SECRET_KEY);

        // Silent host lets the controller fall back to idle
        request_challenge(challenge);
        line_quiet <= 1'b1;
        repeat (RESPONSE_TIMEOUT + 100) @(posedge CLK);
        request_challenge(challenge);

        // Bad blink pattern holds the release until the blink timeout
        auth_and_blink(challenge, 2'd2);

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks so far: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
src/gate_cfg_pkg.sv
src/gate_proto_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/phase_timer.sv
src/blink_detector.sv
src/auth_controller.sv
src/swd_gate_top.sv
verification/swd_gate_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SWD gate simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module swd_gate_tb \
    -f src.f -o swd_gate_sim

./obj_dir/swd_gate_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation passed"
